// ==== Makefile ====
# Verilator build for the display control plane

VERILATOR       ?= verilator
TOP             ?= control_top_tb
FILE_LIST       ?= control_top.f
BUILD_DIR       ?= obj_dir
JOBS            ?= 0
VERILATOR_FLAGS ?= --binary --timing
SOURCES         := $(wildcard hw/*.sv test/*.sv)
SIM             := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Pass only when the simulation prints the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(BUILD_DIR)

// ==== control_top.f ====
hw/spi_protocol_pkg.sv
hw/register_map_pkg.sv
hw/command_bus_if.sv
hw/spi_peripheral.sv
hw/spi_register.sv
hw/scratch_registers.sv
hw/control_top.sv
test/control_top_tb.sv

// ==== hw/command_bus_if.sv ====
// Decoded SPI command bus
`timescale 1ns/1ps

interface command_bus_if import spi_protocol_pkg::*; ();

    logic [byte_width-1:0]          opcode;         // Held until next transaction
    logic                           opcode_valid;   // One clock per transaction
    logic [byte_width-1:0]          operand;
    logic                           operand_valid;  // One clock per operand byte
    logic [operand_count_width-1:0] operand_count;  // 0 for first operand

    // Driven by the SPI peripheral
    modport publisher (
        output opcode,
        output opcode_valid,
        output operand,
        output operand_valid,
        output operand_count
    );

    // Read by every responder
    modport listener (
        input opcode,
        input opcode_valid,
        input operand,
        input operand_valid,
        input operand_count
    );

endinterface

// ==== hw/control_top.sv ====
// Display control plane top
`timescale 1ns/1ps

module control_top
    import spi_protocol_pkg::*;
    import register_map_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic spi_select,
    input  logic spi_clock,
    input  logic spi_data_in,
    output logic spi_data_out
);

    logic [byte_width-1:0] chip_id_response;
    logic                  chip_id_response_valid;
    logic [byte_width-1:0] scratch_response;
    logic                  scratch_response_valid;
    logic [byte_width-1:0] response;
    logic                  response_valid;

    command_bus_if bus ();

    // Idle responders drive zero, so OR merges them
    assign response       = chip_id_response | scratch_response;
    assign response_valid = chip_id_response_valid | scratch_response_valid;

    spi_peripheral spi_peripheral (
        .clock          (clock),
        .reset          (reset),
        .spi_select     (spi_select),
        .spi_clock      (spi_clock),
        .spi_data_in    (spi_data_in),
        .spi_data_out   (spi_data_out),
        .response       (response),
        .response_valid (response_valid),
        .bus            (bus.publisher)
    );

    spi_register #(
        .register_opcode (opcode_chip_id),
        .register_value  (chip_id_value)
    ) chip_id (
        .clock          (clock),
        .reset          (reset),
        .bus            (bus.listener),
        .response       (chip_id_response),
        .response_valid (chip_id_response_valid)
    );

    scratch_registers scratch_registers (
        .clock          (clock),
        .reset          (reset),
        .bus            (bus.listener),
        .response       (scratch_response),
        .response_valid (scratch_response_valid)
    );

endmodule

// ==== hw/register_map_pkg.sv ====
// Control register map

package register_map_pkg;

    // Fixed identification byte returned for the chip ID opcode
    localparam logic [7:0] chip_id_value = 8'h81;

    // Host scratch bank
    localparam int scratch_depth       = 4;
    localparam int scratch_index_width = $clog2(scratch_depth);  // 2 bits for 4 bytes

endpackage

// ==== hw/scratch_registers.sv ====
// Host scratch register bank
`timescale 1ns/1ps

module scratch_registers
    import spi_protocol_pkg::*;
    import register_map_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    command_bus_if.listener       bus,
    output logic [byte_width-1:0] response,
    output logic                  response_valid
);

    logic [byte_width-1:0]          bank [scratch_depth];
    logic [scratch_index_width-1:0] operand_index;
    logic [scratch_index_width-1:0] next_index;

    // Low bits give the index modulo bank depth
    assign operand_index = bus.operand_count[scratch_index_width-1:0];
    assign next_index    = operand_index + scratch_index_width'(1);  // Wraps at the top

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < scratch_depth; i++) begin
                bank[i] <= '0;
            end
            response       <= '0;
            response_valid <= 1'b0;
        end else if (bus.opcode_valid) begin
            if (bus.opcode == opcode_scratch_clear) begin
                for (int i = 0; i < scratch_depth; i++) begin
                    bank[i] <= '0;
                end
            end

            // A read starts at byte 0 and stays valid for the whole transaction
            if (bus.opcode == opcode_scratch_read) begin
                response       <= bank[0];
                response_valid <= 1'b1;
            end else begin
                response       <= '0;
                response_valid <= 1'b0;
            end
        end else if (bus.operand_valid) begin
            if (bus.opcode == opcode_scratch_write) begin
                bank[operand_index] <= bus.operand;
            end
            if (bus.opcode == opcode_scratch_read) begin
                response <= bank[next_index];  // Byte for the next SPI slot
            end
        end
    end

endmodule

// ==== hw/spi_peripheral.sv ====
// SPI command peripheral
`timescale 1ns/1ps

module spi_peripheral import spi_protocol_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  spi_select,
    input  logic                  spi_clock,
    input  logic                  spi_data_in,
    output logic                  spi_data_out,
    input  logic [byte_width-1:0] response,
    input  logic                  response_valid,
    command_bus_if.publisher      bus
);

    logic [sync_stages-1:0] select_sync;
    logic [sync_stages-1:0] clock_sync;
    logic [sync_stages-1:0] data_sync;
    logic                   clock_last;  // Delayed synchronised SPI clock

    logic select_active;
    logic clock_rise;
    logic clock_fall;
    logic sampled_bit;
    logic byte_done;

    peripheral_state_t              state;
    logic [bit_index_width-1:0]     bit_count;
    logic [byte_width-2:0]          rx_shift;  // Bits gathered so far
    logic [byte_width-1:0]          rx_byte;
    logic [byte_width-1:0]          tx_shift;
    logic                           load_pending;
    logic [operand_count_width-1:0] operand_next;

    assign select_active = ~select_sync[sync_stages-1];  // Active low
    assign clock_rise    = clock_sync[sync_stages-1] & ~clock_last;
    assign clock_fall    = ~clock_sync[sync_stages-1] & clock_last;
    assign sampled_bit   = data_sync[sync_stages-1];
    assign rx_byte       = {rx_shift, sampled_bit};
    assign spi_data_out  = tx_shift[byte_width-1];  // MSB first

    // Eighth rising edge of the current byte
    assign byte_done = select_active && clock_rise &&
                       (bit_count == bit_index_width'(byte_width - 1));

    // Control pin synchronisers
    always_ff @(posedge clock) begin
        if (reset) begin
            select_sync <= '1;
            clock_sync  <= '0;
            clock_last  <= 1'b0;
        end else begin
            select_sync <= {select_sync[sync_stages-2:0], spi_select};
            clock_sync  <= {clock_sync[sync_stages-2:0], spi_clock};
            clock_last  <= clock_sync[sync_stages-1];
        end
    end

    // Receive data path
    always_ff @(posedge clock) begin
        data_sync <= {data_sync[sync_stages-2:0], spi_data_in};
        if (clock_rise) begin
            rx_shift <= rx_byte[byte_width-2:0];
        end
        if (byte_done && state == state_opcode) begin
            bus.opcode <= rx_byte;
        end
        if (byte_done && state == state_operand) begin
            bus.operand <= rx_byte;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state             <= state_idle;
            bit_count         <= '0;
            operand_next      <= '0;
            bus.opcode_valid  <= 1'b0;
            bus.operand_valid <= 1'b0;
            bus.operand_count <= '0;
            load_pending      <= 1'b0;
            tx_shift          <= '0;
        end else begin
            bus.opcode_valid  <= 1'b0;
            bus.operand_valid <= 1'b0;
            load_pending      <= bus.opcode_valid | bus.operand_valid;  // Responders answer next

            if (!select_active) begin
                // Released select ends the transaction
                state             <= state_idle;
                bit_count         <= '0;
                operand_next      <= '0;
                bus.operand_count <= '0;
                tx_shift          <= '0;  // First byte of next transaction returns zero
            end else begin
                case (state)
                    state_idle: begin
                        state <= state_opcode;
                    end
                    state_opcode: begin
                        if (byte_done) begin
                            bus.opcode_valid <= 1'b1;
                            state            <= state_operand;
                        end
                    end
                    state_operand: begin
                        if (byte_done) begin
                            bus.operand_valid <= 1'b1;
                            bus.operand_count <= operand_next;
                            if (operand_next != operand_count_max) begin
                                operand_next <= operand_next + 1'b1;
                            end
                        end
                    end
                    default: begin
                        state <= state_idle;
                    end
                endcase

                if (clock_rise && state != state_idle) begin
                    bit_count <= bit_count + 1'b1;  // Wraps after the eighth bit
                end

                // Reload wins over the shift and the fall after the last bit is skipped
                if (load_pending) begin
                    tx_shift <= response_valid ? response : '0;
                end else if (clock_fall && bit_count != '0) begin
                    tx_shift <= {tx_shift[byte_width-2:0], 1'b0};
                end
            end
        end
    end

endmodule

// ==== hw/spi_protocol_pkg.sv ====
// SPI command protocol definitions

package spi_protocol_pkg;

    // Byte framing on the SPI link
    localparam int byte_width      = 8;
    localparam int bit_index_width = $clog2(byte_width);  // Bit counter within a byte

    // Pin synchroniser depth
    localparam int sync_stages = 2;

    // Operand index within one transaction
    localparam int operand_count_width = 8;
    localparam logic [operand_count_width-1:0] operand_count_max = '1;  // Saturates here

    // Host opcodes, first byte of every transaction
    typedef enum logic [byte_width-1:0] {
        opcode_scratch_write = 8'h20,
        opcode_scratch_read  = 8'h21,
        opcode_scratch_clear = 8'h22,
        opcode_chip_id       = 8'hDB
    } opcode_t;

    // Peripheral framing FSM
    typedef enum logic [1:0] {
        state_idle,     // Select high, nothing in flight
        state_opcode,   // Receiving first byte
        state_operand   // Receiving operand bytes
    } peripheral_state_t;

endpackage

// ==== hw/spi_register.sv ====
// Read-only SPI register
`timescale 1ns/1ps

module spi_register import spi_protocol_pkg::*; #(
    parameter opcode_t               register_opcode = opcode_chip_id,
    parameter logic [byte_width-1:0] register_value  = '0
) (
    input  logic                  clock,
    input  logic                  reset,
    command_bus_if.listener       bus,
    output logic [byte_width-1:0] response,
    output logic                  response_valid
);

    // Answer only our opcode, stay silent for the rest
    always_ff @(posedge clock) begin
        if (reset) begin
            response       <= '0;
            response_valid <= 1'b0;
        end else if (bus.opcode_valid) begin
            if (bus.opcode == register_opcode) begin
                response       <= register_value;
                response_valid <= 1'b1;
            end else begin
                response       <= '0;
                response_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== test/control_top_tb.sv ====
// Control plane SPI testbench
`timescale 1ns/1ps

module control_top_tb;

    localparam int clock_period        = 100;  // ns
    localparam int reset_cycles        = 4;
    localparam int half_bit_clocks     = 4;    // One SPI bit is 8 clocks
    localparam int byte_gap_clocks     = 4;
    localparam int select_setup_clocks = 8;
    localparam int select_gap_clocks   = 8;
    localparam int test_count          = 11;
    localparam int max_bytes           = 8;
    localparam int model_depth         = 4;
    localparam int watchdog_ns         = test_count * 40 * 16 * clock_period;

    // Opcodes as the host sees them
    localparam logic [7:0] op_write   = 8'h20;
    localparam logic [7:0] op_read    = 8'h21;
    localparam logic [7:0] op_clear   = 8'h22;
    localparam logic [7:0] op_chip_id = 8'hDB;
    localparam logic [7:0] op_unknown = 8'h55;

    logic clock;
    logic reset;
    logic spi_select;
    logic spi_clock;
    logic spi_data_in;
    logic spi_data_out;

    // Test table
    string      name_table     [test_count];
    logic [7:0] opcode_table   [test_count];
    logic [7:0] operand_table  [test_count][max_bytes];
    int         length_table   [test_count];  // Bytes including the opcode
    logic [7:0] expected_table [test_count][max_bytes];
    bit         model_table    [test_count];  // Expected bytes come from the scratch model

    logic [7:0] scratch_model [model_depth];
    int         entry_count;
    int         seed;
    int         error_count;
    int         passed_tests;
    int         failed_tests;

    control_top UUT (
        .clock        (clock),
        .reset        (reset),
        .spi_select   (spi_select),
        .spi_clock    (spi_clock),
        .spi_data_in  (spi_data_in),
        .spi_data_out (spi_data_out)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // Adds one table row with zero or random operands
    task automatic set_entry(input string name, input logic [7:0] opcode, input int length,
                             input bit random_data, input bit use_model);
        int i;
        name_table[entry_count]   = name;
        opcode_table[entry_count] = opcode;
        length_table[entry_count] = length;
        model_table[entry_count]  = use_model;
        for (i = 0; i < max_bytes; i++) begin
            operand_table[entry_count][i]  = random_data ? 8'($random(seed)) : 8'h00;
            expected_table[entry_count][i] = 8'h00;
        end
        entry_count++;
    endtask

    // Scratch bank model where reply n answers byte n-1
    task automatic predict_scratch(input int t);
        int i;
        int operands;
        operands = length_table[t] - 1;
        expected_table[t][0] = 8'h00;  // First byte always returns zero
        if (opcode_table[t] == op_write) begin
            for (i = 0; i < operands; i++) begin
                scratch_model[i % model_depth] = operand_table[t][i];
                expected_table[t][i + 1] = 8'h00;
            end
        end else if (opcode_table[t] == op_clear) begin
            for (i = 0; i < model_depth; i++) begin
                scratch_model[i] = 8'h00;
            end
        end else if (opcode_table[t] == op_read) begin
            for (i = 1; i < length_table[t]; i++) begin
                expected_table[t][i] = scratch_model[(i - 1) % model_depth];
            end
        end
    endtask

    task automatic build_table;
        int t;
        entry_count = 0;
        set_entry("chip id after reset", op_chip_id, 2, 1'b0, 1'b0);
        expected_table[0][1] = 8'h81;
        set_entry("write four random", op_write, 5, 1'b1, 1'b1);
        set_entry("read back four", op_read, 5, 1'b0, 1'b1);
        set_entry("read wraps past depth", op_read, 7, 1'b0, 1'b1);
        set_entry("write six operands", op_write, 7, 1'b1, 1'b1);
        set_entry("read after long write", op_read, 5, 1'b0, 1'b1);
        set_entry("clear bank", op_clear, 1, 1'b0, 1'b1);
        set_entry("read after clear", op_read, 5, 1'b0, 1'b1);
        set_entry("write before unknown", op_write, 5, 1'b1, 1'b1);
        set_entry("unknown opcode", op_unknown, 3, 1'b1, 1'b0);  // Three zero replies
        set_entry("read after unknown", op_read, 5, 1'b0, 1'b1);
        for (t = 0; t < model_depth; t++) begin
            scratch_model[t] = 8'h00;  // Bank is zero after reset
        end
        for (t = 0; t < test_count; t++) begin
            if (model_table[t]) begin
                predict_scratch(t);
            end
        end
    endtask

    // Mode 0 transfer MSB first with the reply bit taken on each rising spi_clock
    task automatic transfer_byte(input logic [7:0] tx_byte, output logic [7:0] rx_byte);
        int b;
        rx_byte = 8'h00;
        for (b = 7; b >= 0; b--) begin
            spi_data_in = tx_byte[b];
            repeat (half_bit_clocks) @(negedge clock);
            spi_clock = 1'b1;
            rx_byte   = {rx_byte[6:0], spi_data_out};
            repeat (half_bit_clocks) @(negedge clock);
            spi_clock = 1'b0;
        end
        repeat (byte_gap_clocks) @(negedge clock);
    endtask

    task automatic run_transaction(input int t);
        int i;
        int mismatches;
        logic [7:0] tx;
        logic [7:0] rx;
        mismatches = 0;
        spi_select = 1'b0;
        repeat (select_setup_clocks) @(negedge clock);
        for (i = 0; i < length_table[t]; i++) begin
            if (i == 0) begin
                tx = opcode_table[t];
            end else begin
                tx = operand_table[t][i - 1];
            end
            transfer_byte(tx, rx);
            if (rx !== expected_table[t][i]) begin
                $display("[ERROR] %0d ns: spi_data_out byte %0d expected %02h, actual %02h",
                         $time, i, expected_table[t][i], rx);
                mismatches++;
            end
        end
        spi_select = 1'b1;
        repeat (select_gap_clocks) @(negedge clock);
        error_count += mismatches;
        if (mismatches == 0) begin
            passed_tests++;
            $display("Test %0d (%s): pass", t, name_table[t]);
        end else begin
            failed_tests++;
            $display("Test %0d (%s): fail, %0d bad bytes", t, name_table[t], mismatches);
        end
    endtask

    initial begin
        int t;
        reset        = 1'b1;
        spi_select   = 1'b1;
        spi_clock    = 1'b0;
        spi_data_in  = 1'b0;
        seed         = 69;
        error_count  = 0;
        passed_tests = 0;
        failed_tests = 0;
        build_table();
        repeat (reset_cycles) @(negedge clock);
        reset = 1'b0;
        repeat (4) @(negedge clock);
        for (t = 0; t < test_count; t++) begin
            run_transaction(t);
        end
        $display("Tests run: %0d, passed: %0d, failed: %0d, byte mismatches: %0d",
                 test_count, passed_tests, failed_tests, error_count);
        if (error_count == 0 && failed_tests == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #(watchdog_ns);
        $display("Timeout: the test table did not finish within %0d ns", watchdog_ns);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
